// ==== verification/mem_stage_input.txt ====
// kind funct3 address wdata expected stall  (kind 0 alu, 1 load, 2 store, 3 mem check, 4 pwm, f end)
// stall 0 none, 1 must stall, 2 either; for kind 4 wdata is the cycle count
0 0 00000000 12345678 12345678 0
1 2 00000100 00000000 00000100 1
2 2 00000104 A5B6C7D8 00000000 0
1 2 00000104 00000000 A5B6C7D8 0
1 0 00000104 00000000 FFFFFFD8 0
1 4 00000107 00000000 000000A5 0
1 1 00000106 00000000 FFFFA5B6 0
1 5 00000104 00000000 0000C7D8 0
2 0 00000108 00000080 00000000 0
1 2 00000108 00000000 00000180 0
1 0 00000108 00000000 FFFFFF80 0
2 1 0000010E 00001234 00000000 0
1 2 0000010C 00000000 1234010C 0
1 1 0000010E 00000000 00001234 0
1 2 00000208 00000000 00000208 1
3 0 00000104 00000000 A5B6C7D8 0
3 0 00000108 00000000 00000180 0
3 0 0000010C 00000000 1234010C 0
1 2 00000104 00000000 A5B6C7D8 1
1 0 00000108 00000000 FFFFFF80 0
0 0 00000000 CAFEF00D CAFEF00D 0
2 2 40000000 0000000A 00000000 0
2 2 40000004 00000004 00000000 0
1 2 40000000 00000000 0000000A 0
1 2 40000004 00000000 00000004 0
4 0 00000000 0000001E 0000000C 0
f 0 00000000 00000000 00000000 0

// ==== mem_stage.f ====
hdl/mem_stage_pkg.sv
hdl/mem_req_router.sv
hdl/dcache_array.sv
hdl/dcache_ctrl.sv
hdl/pwm_io.sv
hdl/wb_pipe_reg.sv
hdl/mem_stage_top.sv
verification/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - hdl/mem_stage_pkg.sv
  - hdl/mem_req_router.sv
  - hdl/dcache_array.sv
  - hdl/dcache_ctrl.sv
  - hdl/pwm_io.sv
  - hdl/wb_pipe_reg.sv
  - hdl/mem_stage_top.sv
  - target: test
    files:
      - verification/mem_stage_tb.sv

// ==== verification/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int FIELDS      = 6;     // Columns per record
    localparam int MAX_TESTS   = 40;
    localparam int STALL_LIMIT = 200;
    localparam int MEM_WORDS   = 1024;  // 4 KB main memory

    localparam logic [31:0] K_ALU    = 32'h0;
    localparam logic [31:0] K_LOAD   = 32'h1;
    localparam logic [31:0] K_STORE  = 32'h2;
    localparam logic [31:0] K_MEMCHK = 32'h3;
    localparam logic [31:0] K_PWM    = 32'h4;
    localparam logic [31:0] K_END    = 32'hF;

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    logic                 req_rd_i;
    logic                 req_wr_i;
    logic [31:0]          addr_i;
    logic [31:0]          wdata_i;
    logic [2:0]           funct3_i;
    logic                 rd_we_i;
    logic [4:0]           rd_addr_i;
    logic [31:0]          alu_data_i;
    logic                 mem_ready_i;
    mem_stage_pkg::line_t mem_rline_i;
    logic                 rd_we_o;
    logic [4:0]           rd_addr_o;
    logic [31:0]          rd_data_o;
    logic                 stall_o;
    logic                 mem_req_o;
    logic                 mem_we_o;
    logic [31:0]          mem_addr_o;
    mem_stage_pkg::line_t mem_wline_o;
    logic                 pwm_o;

    logic [31:0] vec [FIELDS*MAX_TESTS];
    logic [31:0] mem_words [MEM_WORDS];
    logic [31:0] last_wr_addr;
    int          errors = 0;
    int          checks = 0;
    logic        timed_out = 1'b0;

    always #10 clk_i = ~clk_i;

    mem_stage_top #(.LINES(16), .PWM_W(16)) dut (
        .clk_i (clk_i), .rst_i (rst_i),
        .req_rd_i (req_rd_i), .req_wr_i (req_wr_i), .addr_i (addr_i),
        .wdata_i (wdata_i), .funct3_i (funct3_i), .rd_we_i (rd_we_i),
        .rd_addr_i (rd_addr_i), .alu_data_i (alu_data_i),
        .mem_ready_i (mem_ready_i), .mem_rline_i (mem_rline_i),
        .rd_we_o (rd_we_o), .rd_addr_o (rd_addr_o), .rd_data_o (rd_data_o),
        .stall_o (stall_o), .mem_req_o (mem_req_o), .mem_we_o (mem_we_o),
        .mem_addr_o (mem_addr_o), .mem_wline_o (mem_wline_o), .pwm_o (pwm_o)
    );

    // Main memory answers each line request after 1 to 6 cycles
    initial begin : memory_model
        int unsigned          delay;
        int unsigned          idx;
        logic                 we;
        logic [31:0]          line_addr;
        mem_stage_pkg::line_t wline;
        mem_stage_pkg::line_t rline;
        delay        = $urandom(40);
        mem_ready_i  = 1'b0;
        mem_rline_i  = '0;
        last_wr_addr = 32'hFFFF_FFFF;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = i * 4;        // Word holds its own address
        end
        forever begin
            @(negedge clk_i);
            if (rst_i === 1'b1 && mem_req_o === 1'b1) begin
                we        = mem_we_o;
                line_addr = mem_addr_o;
                wline     = mem_wline_o;
                idx       = line_addr[11:2];
                delay     = 1 + ($urandom % 6);
                repeat (delay) @(posedge clk_i);
                for (int w = 0; w < 4; w++) begin
                    rline.w[w] = mem_words[idx + w];
                end
                if (we) begin
                    for (int w = 0; w < 4; w++) begin
                        mem_words[idx + w] = wline.w[w];
                    end
                    last_wr_addr = line_addr;
                end
                mem_rline_i <= rline;
                mem_ready_i <= 1'b1;
                @(posedge clk_i);
                mem_ready_i <= 1'b0;     // One cycle pulse
            end
        end
    end

    task automatic note_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        errors++;
        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic run_access(input logic [31:0] kind, input logic [2:0] f3,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp_data, input logic [31:0] exp_stall,
                              input logic [4:0] tag);
        int   waited;
        logic saw_stall;
        waited    = 0;
        saw_stall = 1'b0;
        @(posedge clk_i);
        req_rd_i   <= (kind == K_LOAD);
        req_wr_i   <= (kind == K_STORE);
        addr_i     <= addr;
        wdata_i    <= wdata;
        funct3_i   <= f3;
        alu_data_i <= (kind == K_ALU) ? wdata : '0;
        rd_we_i    <= (kind != K_STORE);
        rd_addr_i  <= tag;
        @(negedge clk_i);
        while (stall_o === 1'b1 && waited < STALL_LIMIT) begin
            saw_stall = 1'b1;
            checks++;
            if (rd_we_o !== 1'b0) note_mismatch("rd_we_o during stall", rd_we_o, 0);
            waited++;
            @(negedge clk_i);
        end
        if (stall_o !== 1'b0) begin
            $display("Timeout: stall_o stuck or unknown after %0d cycles, address %h",
                     STALL_LIMIT, addr);
            timed_out = 1'b1;
        end else begin
            @(posedge clk_i);            // Result captured here
            req_rd_i <= 1'b0;
            req_wr_i <= 1'b0;
            rd_we_i  <= 1'b0;
            @(negedge clk_i);
            checks++;
            if (exp_stall != 2 && saw_stall != exp_stall[0])
                note_mismatch("stall seen", saw_stall, exp_stall);
            if (kind == K_STORE) begin
                checks++;
                if (rd_we_o !== 1'b0) note_mismatch("rd_we_o after store", rd_we_o, 0);
            end else begin
                checks += 3;
                if (rd_we_o !== 1'b1) note_mismatch("rd_we_o", rd_we_o, 1);
                if (rd_addr_o !== tag) note_mismatch("rd_addr_o", rd_addr_o, tag);
                if (rd_data_o !== exp_data) note_mismatch("rd_data_o", rd_data_o, exp_data);
            end
        end
    endtask

    // Word in the memory model and the line of the last write-back
    task automatic check_memory(input logic [31:0] addr, input logic [31:0] exp_data);
        checks += 2;
        if (mem_words[addr[11:2]] !== exp_data)
            note_mismatch("memory word", mem_words[addr[11:2]], exp_data);
        if (last_wr_addr !== {addr[31:4], 4'b0000})
            note_mismatch("write-back line address", last_wr_addr, {addr[31:4], 4'b0000});
    endtask

    task automatic count_pwm_high(input int cycles, input int exp_high);
        int high;
        high = 0;
        repeat (cycles) begin
            @(negedge clk_i);
            if (pwm_o === 1'b1) high++;
        end
        checks++;
        if (high != exp_high) note_mismatch("pwm_o high cycles", high, exp_high);
    endtask

    initial begin : sequencer
        int          n;
        int          base;
        int          errs_before;
        logic [31:0] kind;
        string       verdict;
        rst_i      = 1'b0;
        req_rd_i   = 1'b0;
        req_wr_i   = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        funct3_i   = '0;
        rd_we_i    = 1'b0;
        rd_addr_i  = '0;
        alu_data_i = '0;
        for (int i = 0; i < FIELDS*MAX_TESTS; i++) begin
            vec[i] = K_END;
        end
        $readmemh("verification/mem_stage_input.txt", vec);
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b1;
        @(negedge clk_i);
        checks++;
        if ({rd_we_o, mem_req_o, mem_we_o, pwm_o, stall_o} !== 5'b00000)
            note_mismatch("outputs after reset",
                          {rd_we_o, mem_req_o, mem_we_o, pwm_o, stall_o}, 0);
        n    = 0;
        base = 0;
        kind = vec[0];
        while (kind != K_END && n < MAX_TESTS && !timed_out) begin
            errs_before = errors;
            case (kind)
                K_ALU, K_LOAD, K_STORE: run_access(kind, vec[base+1][2:0], vec[base+2],
                                                   vec[base+3], vec[base+4], vec[base+5],
                                                   n[4:0]);
                K_MEMCHK: check_memory(vec[base+2], vec[base+4]);
                K_PWM:    count_pwm_high(vec[base+3], vec[base+4]);
                default: begin
                    errors++;
                    $display("Unknown record kind %h in record %0d", kind, n);
                end
            endcase
            if (timed_out) begin
                verdict = "timeout";
            end else if (errors == errs_before) begin
                verdict = "ok";
            end else begin
                verdict = "mismatch";
            end
            $display("test %0d kind %0h addr %h: %s", n, kind, vec[base+2], verdict);
            n++;
            base = n * FIELDS;
            kind = (n < MAX_TESTS) ? vec[base] : K_END;
        end
        $display("%0d tests, %0d checks, %0d errors", n, checks, errors);
        if (errors == 0 && !timed_out && n > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top #(
    parameter int LINES = 16,
    parameter int PWM_W = 16
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           req_rd_i,
    input  logic                           req_wr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] wdata_i,
    input  logic [2:0]                     funct3_i,
    input  logic                           rd_we_i,
    input  logic [4:0]                     rd_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] alu_data_i,
    input  logic                           mem_ready_i,
    input  mem_stage_pkg::line_t           mem_rline_i,
    output logic                           rd_we_o,
    output logic [4:0]                     rd_addr_o,
    output logic [mem_stage_pkg::XLEN-1:0] rd_data_o,
    output logic                           stall_o,
    output logic                           mem_req_o,
    output logic                           mem_we_o,
    output logic [mem_stage_pkg::XLEN-1:0] mem_addr_o,
    output mem_stage_pkg::line_t           mem_wline_o,
    output logic                           pwm_o
);

    logic                           cache_rd;
    logic                           cache_wr;
    logic                           io_rd;
    logic                           io_wr;
    logic                           ctrl_ready;
    logic                           hit;
    logic                           dirty;
    logic [mem_stage_pkg::XLEN-1:0] victim_addr;
    mem_stage_pkg::line_t           victim_line;
    logic [mem_stage_pkg::XLEN-1:0] cache_rdata;
    logic                           fill;
    mem_stage_pkg::line_t           fill_line;
    logic [mem_stage_pkg::XLEN-1:0] io_rdata;

    mem_req_router u_router (
        .req_rd_i     (req_rd_i),
        .req_wr_i     (req_wr_i),
        .addr_i       (addr_i),
        .ctrl_ready_i (ctrl_ready),
        .cache_rd_o   (cache_rd),
        .cache_wr_o   (cache_wr),
        .io_rd_o      (io_rd),
        .io_wr_o      (io_wr),
        .stall_o      (stall_o)
    );

    dcache_array #(.LINES(LINES)) u_array (
        .clk_i (clk_i), .rst_i (rst_i),
        .rd_i (cache_rd), .wr_i (cache_wr),
        .addr_i (addr_i), .wdata_i (wdata_i), .funct3_i (funct3_i),
        .fill_i (fill), .fill_line_i (fill_line),
        .hit_o (hit), .dirty_o (dirty),
        .victim_addr_o (victim_addr), .victim_line_o (victim_line),
        .rdata_o (cache_rdata)
    );

    dcache_ctrl u_ctrl (
        .clk_i (clk_i), .rst_i (rst_i),
        .cache_rd_i (cache_rd), .cache_wr_i (cache_wr), .addr_i (addr_i),
        .hit_i (hit), .dirty_i (dirty),
        .victim_addr_i (victim_addr), .victim_line_i (victim_line),
        .mem_ready_i (mem_ready_i), .mem_rline_i (mem_rline_i),
        .ctrl_ready_o (ctrl_ready), .fill_o (fill), .fill_line_o (fill_line),
        .mem_req_o (mem_req_o), .mem_we_o (mem_we_o),
        .mem_addr_o (mem_addr_o), .mem_wline_o (mem_wline_o)
    );

    pwm_io #(.PWM_W(PWM_W)) u_pwm (
        .clk_i (clk_i), .rst_i (rst_i),
        .rd_i (io_rd), .wr_i (io_wr),
        .addr_i (addr_i[3:2]), .wdata_i (wdata_i),
        .rdata_o (io_rdata), .pwm_o (pwm_o)
    );

    wb_pipe_reg u_wb (
        .clk_i (clk_i), .rst_i (rst_i), .stall_i (stall_o),
        .load_i (req_rd_i), .io_sel_i (addr_i[mem_stage_pkg::IO_SEL_BIT]),
        .cache_data_i (cache_rdata), .io_data_i (io_rdata), .alu_data_i (alu_data_i),
        .rd_we_i (rd_we_i), .rd_addr_i (rd_addr_i),
        .rd_we_o (rd_we_o), .rd_addr_o (rd_addr_o), .rd_data_o (rd_data_o)
    );

endmodule

// ==== hdl/wb_pipe_reg.sv ====
`timescale 1ns/1ps

module wb_pipe_reg (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           stall_i,
    input  logic                           load_i,
    input  logic                           io_sel_i,
    input  logic [mem_stage_pkg::XLEN-1:0] cache_data_i,
    input  logic [mem_stage_pkg::XLEN-1:0] io_data_i,
    input  logic [mem_stage_pkg::XLEN-1:0] alu_data_i,
    input  logic                           rd_we_i,
    input  logic [4:0]                     rd_addr_i,
    output logic                           rd_we_o,
    output logic [4:0]                     rd_addr_o,
    output logic [mem_stage_pkg::XLEN-1:0] rd_data_o
);

    logic [mem_stage_pkg::XLEN-1:0] wb_data;

    // Load result or ALU pass-through
    assign wb_data = load_i ? (io_sel_i ? io_data_i : cache_data_i) : alu_data_i;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rd_we_o <= 1'b0;
        end else begin
            rd_we_o <= rd_we_i && !stall_i;   // Bubble while stalled
        end
    end

    // Payload holds its value during a stall
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            rd_addr_o <= rd_addr_i;
            rd_data_o <= wb_data;
        end
    end

endmodule

// ==== hdl/pwm_io.sv ====
`timescale 1ns/1ps

module pwm_io #(
    parameter int PWM_W = 16
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           rd_i,
    input  logic                           wr_i,
    input  logic [3:2]                     addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] wdata_i,
    output logic [mem_stage_pkg::XLEN-1:0] rdata_o,
    output logic                           pwm_o
);

    logic [PWM_W-1:0] period_q;
    logic [PWM_W-1:0] duty_q;
    logic [PWM_W-1:0] cnt_q;
    logic             wrap;

    // Register writes
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            period_q <= '0;
            duty_q   <= '0;
        end else if (wr_i) begin
            case (addr_i)
                2'd0:    period_q <= wdata_i[PWM_W-1:0];
                2'd1:    duty_q   <= wdata_i[PWM_W-1:0];
                default: ;
            endcase
        end
    end

    // Zero extended read back
    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            case (addr_i)
                2'd0:    rdata_o = {{(mem_stage_pkg::XLEN-PWM_W){1'b0}}, period_q};
                2'd1:    rdata_o = {{(mem_stage_pkg::XLEN-PWM_W){1'b0}}, duty_q};
                default: rdata_o = '0;
            endcase
        end
    end

    // Also covers a period shrunk below the count
    assign wrap = (period_q == '0) || (cnt_q >= period_q - 1'b1);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= wrap ? '0 : cnt_q + 1'b1;
        end
    end

    assign pwm_o = (cnt_q < duty_q);

endmodule

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           cache_rd_i,
    input  logic                           cache_wr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] addr_i,
    input  logic                           hit_i,
    input  logic                           dirty_i,
    input  logic [mem_stage_pkg::XLEN-1:0] victim_addr_i,
    input  mem_stage_pkg::line_t           victim_line_i,
    input  logic                           mem_ready_i,
    input  mem_stage_pkg::line_t           mem_rline_i,
    output logic                           ctrl_ready_o,
    output logic                           fill_o,
    output mem_stage_pkg::line_t           fill_line_o,
    output logic                           mem_req_o,
    output logic                           mem_we_o,
    output logic [mem_stage_pkg::XLEN-1:0] mem_addr_o,
    output mem_stage_pkg::line_t           mem_wline_o
);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_WB     = 2'd1;
    localparam logic [1:0] S_REFILL = 2'd2;
    localparam logic [1:0] S_FILL   = 2'd3;

    logic [1:0]                     state_q;
    logic [1:0]                     state_d;
    logic                           access;
    logic                           miss;
    logic [mem_stage_pkg::XLEN-1:0] line_addr;
    logic [mem_stage_pkg::XLEN-1:0] mem_addr_q;
    mem_stage_pkg::line_t           wline_q;
    mem_stage_pkg::line_t           rline_q;

    assign access    = cache_rd_i || cache_wr_i;
    assign miss      = access && !hit_i;
    assign line_addr = {addr_i[mem_stage_pkg::XLEN-1:4], 4'b0000};

    // Ready only in idle with nothing missing
    assign ctrl_ready_o = (state_q == S_IDLE) && !miss;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (miss) begin
                    state_d = dirty_i ? S_WB : S_REFILL;
                end
            end
            S_WB: begin
                if (mem_ready_i) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (mem_ready_i) begin
                    state_d = S_FILL;
                end
            end
            default: state_d = S_IDLE;   // Fill lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Latched so memory sees stable values while it waits
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && miss) begin
            mem_addr_q <= dirty_i ? victim_addr_i : line_addr;
            wline_q    <= victim_line_i;
        end else if (state_q == S_WB && mem_ready_i) begin
            mem_addr_q <= line_addr;             // Switch to refill address
        end
        if (state_q == S_REFILL && mem_ready_i) begin
            rline_q <= mem_rline_i;
        end
    end

    assign mem_req_o   = (state_q == S_WB) || (state_q == S_REFILL);
    assign mem_we_o    = (state_q == S_WB);
    assign mem_addr_o  = mem_addr_q;
    assign mem_wline_o = wline_q;

    assign fill_o      = (state_q == S_FILL);
    assign fill_line_o = rline_q;

endmodule

// ==== hdl/dcache_array.sv ====
`timescale 1ns/1ps

module dcache_array #(
    parameter int LINES = 16
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           rd_i,
    input  logic                           wr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] wdata_i,
    input  logic [2:0]                     funct3_i,
    input  logic                           fill_i,
    input  mem_stage_pkg::line_t           fill_line_i,
    output logic                           hit_o,
    output logic                           dirty_o,
    output logic [mem_stage_pkg::XLEN-1:0] victim_addr_o,
    output mem_stage_pkg::line_t           victim_line_o,
    output logic [mem_stage_pkg::XLEN-1:0] rdata_o
);

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = mem_stage_pkg::XLEN - IDX_W - 4;

    logic [TAG_W-1:0]     tag_q [LINES];
    mem_stage_pkg::line_t data_q [LINES];
    logic [LINES-1:0]     valid_q;
    logic [LINES-1:0]     dirty_q;

    logic [IDX_W-1:0]     idx;
    logic [TAG_W-1:0]     tag;
    mem_stage_pkg::line_t cur_line;
    mem_stage_pkg::line_t merged;
    logic [7:0]           byte_sel;
    logic [15:0]          half_sel;

    assign idx      = addr_i[IDX_W+3:4];
    assign tag      = addr_i[mem_stage_pkg::XLEN-1:IDX_W+4];
    assign cur_line = data_q[idx];

    assign hit_o         = (rd_i || wr_i) && valid_q[idx] && (tag_q[idx] == tag);
    assign dirty_o       = valid_q[idx] && dirty_q[idx];
    assign victim_addr_o = {tag_q[idx], idx, 4'b0000};   // Line aligned
    assign victim_line_o = cur_line;

    assign byte_sel = cur_line.b[addr_i[3:0]];
    assign half_sel = {cur_line.b[{addr_i[3:1], 1'b1}], cur_line.b[{addr_i[3:1], 1'b0}]};

    // Load extraction
    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            case (funct3_i)
                mem_stage_pkg::LSU_LB:  rdata_o = {{(mem_stage_pkg::XLEN-8){byte_sel[7]}}, byte_sel};
                mem_stage_pkg::LSU_LH:  rdata_o = {{(mem_stage_pkg::XLEN-16){half_sel[15]}}, half_sel};
                mem_stage_pkg::LSU_LBU: rdata_o = {{(mem_stage_pkg::XLEN-8){1'b0}}, byte_sel};
                mem_stage_pkg::LSU_LHU: rdata_o = {{(mem_stage_pkg::XLEN-16){1'b0}}, half_sel};
                default:                rdata_o = cur_line.w[addr_i[3:2]];
            endcase
        end
    end

    // Store merge reading the load codes as SB/SH/SW
    always_comb begin
        merged = cur_line;
        case (funct3_i)
            mem_stage_pkg::LSU_LB: merged.b[addr_i[3:0]] = wdata_i[7:0];
            mem_stage_pkg::LSU_LH: begin
                merged.b[{addr_i[3:1], 1'b0}] = wdata_i[7:0];
                merged.b[{addr_i[3:1], 1'b1}] = wdata_i[15:8];
            end
            default: merged.w[addr_i[3:2]] = wdata_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            data_q[idx] <= fill_line_i;
            tag_q[idx]  <= tag;
        end else if (wr_i && hit_o) begin
            data_q[idx] <= merged;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_i) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;        // Refilled lines are clean
        end else if (wr_i && hit_o) begin
            dirty_q[idx] <= 1'b1;
        end
    end

endmodule

// ==== hdl/mem_req_router.sv ====
`timescale 1ns/1ps

module mem_req_router (
    input  logic                           req_rd_i,
    input  logic                           req_wr_i,
    input  logic [mem_stage_pkg::XLEN-1:0] addr_i,
    input  logic                           ctrl_ready_i,
    output logic                           cache_rd_o,
    output logic                           cache_wr_o,
    output logic                           io_rd_o,
    output logic                           io_wr_o,
    output logic                           stall_o
);

    logic io_sel;

    assign io_sel = addr_i[mem_stage_pkg::IO_SEL_BIT];

    // Cacheable space
    assign cache_rd_o = req_rd_i && !io_sel;
    assign cache_wr_o = req_wr_i && !io_sel;

    // Peripheral space finishes in one cycle
    assign io_rd_o = req_rd_i && io_sel;
    assign io_wr_o = req_wr_i && io_sel;

    // Only a cache access can hold the pipeline
    assign stall_o = (cache_rd_o || cache_wr_o) && !ctrl_ready_i;

endmodule

// ==== hdl/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // Data path and address width
    localparam int XLEN = 32;

    // One cache line is four words
    localparam int LINE_W = 128;

    // Address bit that selects the I/O space
    localparam int IO_SEL_BIT = 30;

    // Load codes, RISC-V funct3
    // Stores reuse 0, 1 and 2 as SB, SH and SW
    localparam logic [2:0] LSU_LB  = 3'b000;
    localparam logic [2:0] LSU_LH  = 3'b001;
    localparam logic [2:0] LSU_LW  = 3'b010;
    localparam logic [2:0] LSU_LBU = 3'b100;
    localparam logic [2:0] LSU_LHU = 3'b101;

    // Word view for word accesses, byte view for sub-word ones
    typedef union packed {
        logic [LINE_W/XLEN-1:0][XLEN-1:0] w;
        logic [LINE_W/8-1:0][7:0]         b;
    } line_t;

endpackage
